//--- src/isa_pkg.sv
package isa_pkg;

	localparam int xlen = 32;
	localparam int reg_addr_w = 5;

	// first fetch after reset
	localparam logic [xlen-1:0] reset_pc = 32'hbfc0_0000;

	// access size code, same on both ports
	localparam logic [1:0] size_word = 2'b10;

	typedef enum logic [5:0] {
		op_special = 6'h00,
		op_j       = 6'h02,
		op_beq     = 6'h04,
		op_bne     = 6'h05,
		op_addiu   = 6'h09,
		op_lui     = 6'h0f,
		op_lw      = 6'h23,
		op_sw      = 6'h2b
	} opcode_t;

	typedef enum logic [5:0] {
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_slt  = 6'h2a
	} funct_t;

endpackage

//--- src/pipe_pkg.sv
package pipe_pkg;

	typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_slt, alu_lui} alu_op_t;

	// decode operand source
	typedef enum logic [1:0] {fwd_regfile, fwd_mem, fwd_wb} fwd_sel_t;

	typedef struct packed {
		logic                              valid;
		logic [isa_pkg::xlen-1:0]          pc;
		logic [isa_pkg::xlen-1:0]          a;
		logic [isa_pkg::xlen-1:0]          b;
		logic [isa_pkg::xlen-1:0]          imm;
		alu_op_t                           alu_op;
		logic                              use_imm;
		logic [isa_pkg::reg_addr_w-1:0]    dest;
		logic                              reg_write;
		logic                              mem_read;
		logic                              mem_write;
	} de_rec_t;

	typedef struct packed {
		logic                              valid;
		logic [isa_pkg::xlen-1:0]          pc;
		logic [isa_pkg::xlen-1:0]          result;
		logic [isa_pkg::xlen-1:0]          store_data;
		logic [isa_pkg::reg_addr_w-1:0]    dest;
		logic                              reg_write;
		logic                              mem_read;
		logic                              mem_write;
	} em_rec_t;

	typedef struct packed {
		logic                              valid;
		logic [isa_pkg::xlen-1:0]          pc;
		logic [isa_pkg::reg_addr_w-1:0]    dest;
		logic                              reg_write;
		logic [isa_pkg::xlen-1:0]          data;
	} wb_rec_t;

endpackage

//--- src/sram_if.sv
interface sram_if;
	logic        req;
	logic        wr;
	logic [1:0]  size;
	logic [31:0] addr;
	logic [31:0] wdata;
	logic [31:0] rdata;
	logic        addr_ok;
	logic        data_ok;

	modport master (output req, wr, size, addr, wdata, input rdata, addr_ok, data_ok);
	modport slave (input req, wr, size, addr, wdata, output rdata, addr_ok, data_ok);
endinterface

//--- src/fetch_stage.sv
module fetch_stage (
	input  logic        clk,
	input  logic        reset,
	sram_if.master      imem,
	input  logic        redirect,
	input  logic [31:0] target,
	input  logic        stall,
	output logic        inst_valid,
	output logic [31:0] inst,
	output logic [31:0] pc,
	output logic        busy
);
	import isa_pkg::*;

	logic [xlen-1:0] fetch_pc;
	logic [xlen-1:0] req_pc;
	logic [xlen-1:0] pend_target;
	logic            pend;
	logic            waiting;
	logic            started;
	logic            buf_valid;
	logic            take;
	logic            accept;

	assign take = buf_valid && !stall;
	assign accept = imem.req && imem.addr_ok;

	// one access in flight, next one only once the buffer frees up
	assign imem.req = started && !waiting && (!buf_valid || take);
	assign imem.wr = 1'b0;
	assign imem.size = size_word;
	assign imem.addr = fetch_pc;
	assign imem.wdata = '0;

	assign inst_valid = buf_valid;
	assign busy = !buf_valid;

	always_ff @(posedge clk) begin
		if (reset) begin
			started <= 1'b0;
			waiting <= 1'b0;
			buf_valid <= 1'b0;
			pend <= 1'b0;
			fetch_pc <= reset_pc;
		end else begin
			started <= 1'b1;
			// redirect lands after the delay slot request goes out
			if (accept) begin
				waiting <= 1'b1;
				pend <= 1'b0;
				fetch_pc <= redirect ? target : (pend ? pend_target : fetch_pc + 32'd4);
			end else if (redirect) begin
				pend <= 1'b1;
			end
			if (take)
				buf_valid <= 1'b0;
			if (imem.data_ok) begin
				waiting <= 1'b0;
				buf_valid <= 1'b1;
			end
		end
		if (redirect)
			pend_target <= target;
		if (accept)
			req_pc <= fetch_pc;
		if (imem.data_ok) begin
			inst <= imem.rdata;
			pc <= req_pc;
		end
	end

	a_req_held: assert property (@(posedge clk) disable iff (reset)
		imem.req && !imem.addr_ok |=> imem.req && $stable(imem.addr));

endmodule

//--- src/decode_stage.sv
module decode_stage (
	input  logic               clk,
	input  logic               reset,
	input  logic               inst_valid,
	input  logic [31:0]        inst,
	input  logic [31:0]        pc,
	input  logic               stall_d,
	input  logic               stall_all,
	input  pipe_pkg::fwd_sel_t fwd_a,
	input  pipe_pkg::fwd_sel_t fwd_b,
	input  pipe_pkg::em_rec_t  mem_fwd,
	input  pipe_pkg::wb_rec_t  wb,
	output logic               redirect,
	output logic [31:0]        target,
	output logic [4:0]         src_a,
	output logic [4:0]         src_b,
	output logic               use_a,
	output logic               use_b,
	output pipe_pkg::de_rec_t  de
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic [xlen-1:0]       rf [32];
	opcode_t               op;
	funct_t                fn;
	alu_op_t               alu_op;
	logic                  use_imm;
	logic                  reg_write;
	logic                  mem_read;
	logic                  mem_write;
	logic                  is_branch;
	logic                  is_j;
	logic [reg_addr_w-1:0] dest;
	logic [xlen-1:0]       opnd_a;
	logic [xlen-1:0]       opnd_b;
	logic [xlen-1:0]       imm_ext;
	logic [xlen-1:0]       pc4;
	logic                  taken;

	function automatic logic [xlen-1:0] pick(fwd_sel_t sel, logic [reg_addr_w-1:0] idx);
		logic [xlen-1:0] val;
		case (sel)
			fwd_mem: val = mem_fwd.result;
			fwd_wb:  val = wb.data;
			default: val = (idx == '0) ? '0 : rf[idx];
		endcase
		return val;
	endfunction

	assign op = opcode_t'(inst[31:26]);
	assign fn = funct_t'(inst[5:0]);
	assign src_a = inst[25:21];
	assign src_b = inst[20:16];
	assign imm_ext = {{16{inst[15]}}, inst[15:0]};
	assign pc4 = pc + 32'd4;

	always_comb begin
		alu_op = alu_add;
		use_imm = 1'b1;
		reg_write = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		is_branch = 1'b0;
		is_j = 1'b0;
		use_a = 1'b0;
		use_b = 1'b0;
		dest = inst[20:16];
		case (op)
			op_special: begin
				use_a = 1'b1;
				use_b = 1'b1;
				use_imm = 1'b0;
				dest = inst[15:11];
				reg_write = 1'b1;
				case (fn)
					fn_addu: alu_op = alu_add;
					fn_subu: alu_op = alu_sub;
					fn_and:  alu_op = alu_and;
					fn_or:   alu_op = alu_or;
					fn_slt:  alu_op = alu_slt;
					default: reg_write = 1'b0;
				endcase
			end
			op_addiu: begin
				use_a = 1'b1;
				reg_write = 1'b1;
			end
			op_lui: begin
				alu_op = alu_lui;
				reg_write = 1'b1;
			end
			op_lw: begin
				use_a = 1'b1;
				reg_write = 1'b1;
				mem_read = 1'b1;
			end
			op_sw: begin
				use_a = 1'b1;
				use_b = 1'b1;
				mem_write = 1'b1;
			end
			op_beq, op_bne: begin
				use_a = 1'b1;
				use_b = 1'b1;
				is_branch = 1'b1;
			end
			op_j: is_j = 1'b1;
			default: ;
		endcase
	end

	////////////////////
	// branch resolve
	////////////////////
	assign opnd_a = pick(fwd_a, src_a);
	assign opnd_b = pick(fwd_b, src_b);
	assign taken = is_branch && ((op == op_beq) == (opnd_a == opnd_b));
	assign target = is_j ? {pc4[31:28], inst[25:0], 2'b00} : pc4 + {imm_ext[29:0], 2'b00};
	assign redirect = inst_valid && !stall_d && !stall_all && (is_j || taken);

	// register file, r0 never written
	always_ff @(posedge clk) begin
		if (wb.valid && wb.reg_write && wb.dest != '0)
			rf[wb.dest] <= wb.data;
	end

	always_ff @(posedge clk) begin
		if (reset)
			de.valid <= 1'b0;
		else if (!stall_all)
			de.valid <= inst_valid && !stall_d;
		if (!stall_all) begin
			de.pc <= pc;
			de.a <= opnd_a;
			de.b <= opnd_b;
			de.imm <= imm_ext;
			de.alu_op <= alu_op;
			de.use_imm <= use_imm;
			de.dest <= dest;
			de.reg_write <= reg_write;
			de.mem_read <= mem_read;
			de.mem_write <= mem_write;
		end
	end

endmodule

//--- src/exec_stage.sv
module exec_stage (
	input  logic              clk,
	input  logic              reset,
	input  logic              stall_all,
	input  pipe_pkg::de_rec_t de,
	output pipe_pkg::em_rec_t em
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic [xlen-1:0] src2;
	logic [xlen-1:0] result;

	assign src2 = de.use_imm ? de.imm : de.b;

	always_comb begin
		case (de.alu_op)
			alu_sub: result = de.a - src2;
			alu_and: result = de.a & src2;
			alu_or:  result = de.a | src2;
			alu_slt: result = {31'b0, $signed(de.a) < $signed(src2)};
			alu_lui: result = {de.imm[15:0], 16'b0};
			default: result = de.a + src2;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			em.valid <= 1'b0;
		else if (!stall_all)
			em.valid <= de.valid;
		if (!stall_all) begin
			em.pc <= de.pc;
			em.result <= result;
			em.store_data <= de.b;
			em.dest <= de.dest;
			em.reg_write <= de.reg_write;
			em.mem_read <= de.mem_read;
			em.mem_write <= de.mem_write;
		end
	end

endmodule

//--- src/mem_stage.sv
module mem_stage (
	input  logic              clk,
	input  logic              reset,
	sram_if.master            dmem,
	input  pipe_pkg::em_rec_t em,
	input  logic              stall_all,
	output logic              busy,
	output pipe_pkg::wb_rec_t wb,
	output logic [31:0]       debug_wb_pc,
	output logic [3:0]        debug_wb_rf_wen,
	output logic [4:0]        debug_wb_rf_wnum,
	output logic [31:0]       debug_wb_rf_wdata
);
	import isa_pkg::*;

	logic            access;
	logic            waiting;
	logic            done;
	logic [xlen-1:0] ld_data;
	logic [xlen-1:0] rd_val;

	assign access = em.valid && (em.mem_read || em.mem_write);

	// done holds the result while the rest of the pipe is frozen
	assign dmem.req = access && !waiting && !done;
	assign dmem.wr = em.valid && em.mem_write && !waiting && !done;
	assign dmem.size = size_word;
	assign dmem.addr = em.result;
	assign dmem.wdata = em.store_data;

	assign busy = access && !done && !dmem.data_ok;
	assign rd_val = done ? ld_data : dmem.rdata;

	always_ff @(posedge clk) begin
		if (reset) begin
			waiting <= 1'b0;
			done <= 1'b0;
			wb.valid <= 1'b0;
		end else begin
			if (dmem.req && dmem.addr_ok)
				waiting <= 1'b1;
			if (dmem.data_ok)
				waiting <= 1'b0;
			done <= stall_all && (done || dmem.data_ok);
			// bubble while frozen so each record retires once
			wb.valid <= em.valid && !stall_all;
		end
		if (dmem.data_ok)
			ld_data <= dmem.rdata;
		wb.pc <= em.pc;
		wb.dest <= em.dest;
		wb.reg_write <= em.reg_write;
		wb.data <= em.mem_read ? rd_val : em.result;
	end

	////////////////////
	// trace
	////////////////////
	assign debug_wb_pc = wb.pc;
	assign debug_wb_rf_wen = {4{wb.valid && wb.reg_write && wb.dest != '0}};
	assign debug_wb_rf_wnum = wb.dest;
	assign debug_wb_rf_wdata = wb.data;

	a_req_held: assert property (@(posedge clk) disable iff (reset)
		dmem.req && !dmem.addr_ok |=> dmem.req && $stable(dmem.addr));

endmodule

//--- src/hazard_ctrl.sv
module hazard_ctrl (
	input  logic               [4:0] src_a,
	input  logic               [4:0] src_b,
	input  logic               use_a,
	input  logic               use_b,
	input  pipe_pkg::de_rec_t  de,
	input  pipe_pkg::em_rec_t  em,
	input  pipe_pkg::wb_rec_t  wb,
	input  logic               fetch_busy,
	input  logic               mem_busy,
	output logic               stall_d,
	output logic               stall_all,
	output pipe_pkg::fwd_sel_t fwd_a,
	output pipe_pkg::fwd_sel_t fwd_b
);
	import pipe_pkg::*;

	function automatic logic hits(logic v, logic w, logic [4:0] d, logic [4:0] s);
		return v && w && d == s && s != '0;
	endfunction

	function automatic fwd_sel_t pick(logic [4:0] s);
		if (hits(em.valid, em.reg_write, em.dest, s))
			return fwd_mem;
		if (hits(wb.valid, wb.reg_write, wb.dest, s))
			return fwd_wb;
		return fwd_regfile;
	endfunction

	assign fwd_a = pick(src_a);
	assign fwd_b = pick(src_b);

	// no forward out of execute, and load data is too late in mem
	assign stall_d = (use_a && hits(de.valid, de.reg_write, de.dest, src_a))
		|| (use_b && hits(de.valid, de.reg_write, de.dest, src_b))
		|| (use_a && fwd_a == fwd_mem && em.mem_read)
		|| (use_b && fwd_b == fwd_mem && em.mem_read);

	assign stall_all = fetch_busy || mem_busy;

endmodule

//--- src/mycpu_top.sv
module mycpu_top (
	input  logic        clk,
	input  logic        reset,
	output logic        inst_req,
	output logic        inst_wr,
	output logic [1:0]  inst_size,
	output logic [31:0] inst_addr,
	output logic [31:0] inst_wdata,
	input  logic [31:0] inst_rdata,
	input  logic        inst_addr_ok,
	input  logic        inst_data_ok,
	output logic        data_req,
	output logic        data_wr,
	output logic [1:0]  data_size,
	output logic [31:0] data_addr,
	output logic [31:0] data_wdata,
	input  logic [31:0] data_rdata,
	input  logic        data_addr_ok,
	input  logic        data_data_ok,
	output logic [31:0] debug_wb_pc,
	output logic [3:0]  debug_wb_rf_wen,
	output logic [4:0]  debug_wb_rf_wnum,
	output logic [31:0] debug_wb_rf_wdata
);
	import pipe_pkg::*;

	sram_if imem ();
	sram_if dmem ();

	logic        redirect;
	logic [31:0] target;
	logic        inst_valid;
	logic [31:0] inst;
	logic [31:0] d_pc;
	logic        fetch_busy;
	logic        mem_busy;
	logic        stall_d;
	logic        stall_all;
	logic [4:0]  src_a;
	logic [4:0]  src_b;
	logic        use_a;
	logic        use_b;
	fwd_sel_t    fwd_a;
	fwd_sel_t    fwd_b;
	de_rec_t     de;
	em_rec_t     em;
	wb_rec_t     wb;

	assign inst_req = imem.req;
	assign inst_wr = imem.wr;
	assign inst_size = imem.size;
	assign inst_addr = imem.addr;
	assign inst_wdata = imem.wdata;
	assign imem.rdata = inst_rdata;
	assign imem.addr_ok = inst_addr_ok;
	assign imem.data_ok = inst_data_ok;

	assign data_req = dmem.req;
	assign data_wr = dmem.wr;
	assign data_size = dmem.size;
	assign data_addr = dmem.addr;
	assign data_wdata = dmem.wdata;
	assign dmem.rdata = data_rdata;
	assign dmem.addr_ok = data_addr_ok;
	assign dmem.data_ok = data_data_ok;

	fetch_stage u_fetch (
		.clk(clk), .reset(reset), .imem(imem),
		.redirect(redirect), .target(target), .stall(stall_d | stall_all),
		.inst_valid(inst_valid), .inst(inst), .pc(d_pc), .busy(fetch_busy)
	);

	decode_stage u_decode (
		.clk(clk), .reset(reset), .inst_valid(inst_valid), .inst(inst), .pc(d_pc),
		.stall_d(stall_d), .stall_all(stall_all), .fwd_a(fwd_a), .fwd_b(fwd_b),
		.mem_fwd(em), .wb(wb), .redirect(redirect), .target(target),
		.src_a(src_a), .src_b(src_b), .use_a(use_a), .use_b(use_b), .de(de)
	);

	exec_stage u_exec (
		.clk(clk), .reset(reset), .stall_all(stall_all), .de(de), .em(em)
	);

	mem_stage u_mem (
		.clk(clk), .reset(reset), .dmem(dmem), .em(em), .stall_all(stall_all),
		.busy(mem_busy), .wb(wb),
		.debug_wb_pc(debug_wb_pc), .debug_wb_rf_wen(debug_wb_rf_wen),
		.debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
	);

	hazard_ctrl u_hazard (
		.src_a(src_a), .src_b(src_b), .use_a(use_a), .use_b(use_b),
		.de(de), .em(em), .wb(wb), .fetch_busy(fetch_busy), .mem_busy(mem_busy),
		.stall_d(stall_d), .stall_all(stall_all), .fwd_a(fwd_a), .fwd_b(fwd_b)
	);

endmodule

//--- test/tb_top.sv
module latency_mem (
	input  logic        clk,
	input  logic        reset,
	input  logic        req,
	input  logic        wr,
	input  logic [31:0] addr,
	input  logic [31:0] wdata,
	output logic [31:0] rdata,
	output logic        addr_ok,
	output logic        data_ok
);
	timeunit 1ns;
	timeprecision 100ps;

	// longest random wait on either handshake
	localparam int unsigned max_delay = 3;

	logic [31:0] mem [64];

	initial begin : serve
		bit          accepted;
		bit          busy;
		bit          in_reset;
		bit          acc_wr;
		logic [31:0] acc_addr;
		logic [31:0] acc_wdata;
		int unsigned gap;
		int unsigned lat;
		accepted = 1'b0;
		busy = 1'b0;
		in_reset = 1'b1;
		gap = $urandom(28) % (max_delay + 1);
		lat = 0;
		addr_ok = 1'b0;
		data_ok = 1'b0;
		rdata = '0;
		forever begin
			// request lines have settled by the falling edge
			@(negedge clk);
			in_reset = reset;
			accepted = !in_reset && req && addr_ok;
			if (accepted) begin
				acc_wr = wr;
				acc_addr = addr;
				acc_wdata = wdata;
			end
			@(posedge clk);
			#1;
			data_ok = 1'b0;
			if (in_reset) begin
				busy = 1'b0;
				addr_ok = 1'b0;
				gap = $urandom_range(max_delay, 0);
			end else if (busy || accepted) begin
				if (accepted) begin
					busy = 1'b1;
					addr_ok = 1'b0;
					lat = $urandom_range(max_delay, 0);
				end
				if (lat == 0) begin
					data_ok = 1'b1;
					if (acc_wr)
						mem[acc_addr[7:2]] = acc_wdata;
					else
						rdata = mem[acc_addr[7:2]];
					busy = 1'b0;
					gap = $urandom_range(max_delay, 0);
				end else begin
					lat--;
				end
			end else begin
				addr_ok = (gap == 0);
				if (gap != 0)
					gap--;
			end
		end
	end

endmodule

module tb_top;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int data_base = 'h40;
	localparam int trace_base = 'h50;
	localparam int cycles_per_write = 40;
	localparam int timeout_slack = 100;
	localparam int settle_cycles = 20;
	localparam logic [1:0] word_size = 2'b10;

	logic        clk;
	logic        reset;
	logic        inst_req;
	logic        inst_wr;
	logic [1:0]  inst_size;
	logic [31:0] inst_addr;
	logic [31:0] inst_wdata;
	logic [31:0] inst_rdata;
	logic        inst_addr_ok;
	logic        inst_data_ok;
	logic        data_req;
	logic        data_wr;
	logic [1:0]  data_size;
	logic [31:0] data_addr;
	logic [31:0] data_wdata;
	logic [31:0] data_rdata;
	logic        data_addr_ok;
	logic        data_data_ok;
	logic [31:0] debug_wb_pc;
	logic [3:0]  debug_wb_rf_wen;
	logic [4:0]  debug_wb_rf_wnum;
	logic [31:0] debug_wb_rf_wdata;

	logic [31:0] tdata [256];
	int          trace_len = 0;
	int          trace_idx = 0;
	int          pass_cnt = 0;
	int          fail_cnt = 0;
	int          port_errors = 0;
	int          cycle_cnt = 0;
	int          limit = 0;

	mycpu_top u_dut (.*);

	latency_mem u_imem (
		.clk(clk), .reset(reset), .req(inst_req), .wr(inst_wr), .addr(inst_addr),
		.wdata(inst_wdata), .rdata(inst_rdata), .addr_ok(inst_addr_ok),
		.data_ok(inst_data_ok)
	);

	latency_mem u_dmem (
		.clk(clk), .reset(reset), .req(data_req), .wr(data_wr), .addr(data_addr),
		.wdata(data_wdata), .rdata(data_rdata), .addr_ok(data_addr_ok),
		.data_ok(data_data_ok)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic compare_value(input string test, input string field,
			input logic [31:0] expected, input logic [31:0] actual, output bit same);
		same = (actual === expected);
		if (!same)
			$display("mismatch %s %s expected %h actual %h", test, field, expected, actual);
	endtask

	////////////////////
	// trace checker
	////////////////////
	task automatic check_write();
		string name;
		bit    ok_pc;
		bit    ok_num;
		bit    ok_data;
		bit    ok_wen;
		if (trace_idx >= trace_len) begin
			$display("unexpected write of r%0d at pc %h after the trace ended",
				debug_wb_rf_wnum, debug_wb_pc);
			fail_cnt++;
		end else begin
			name = $sformatf("write_%0d", trace_idx);
			compare_value(name, "pc", tdata[trace_base + 3 * trace_idx], debug_wb_pc, ok_pc);
			compare_value(name, "wnum", tdata[trace_base + 3 * trace_idx + 1],
				{27'b0, debug_wb_rf_wnum}, ok_num);
			compare_value(name, "wdata", tdata[trace_base + 3 * trace_idx + 2],
				debug_wb_rf_wdata, ok_data);
			compare_value(name, "wen", 32'h0000_000f, {28'b0, debug_wb_rf_wen}, ok_wen);
			if (ok_pc && ok_num && ok_data && ok_wen) begin
				pass_cnt++;
				$display("%s ok", name);
			end else begin
				fail_cnt++;
				$display("%s failed", name);
			end
			trace_idx++;
		end
	endtask

	// every access on either port is a word, and fetch never writes
	task automatic check_ports();
		bit ok_isize;
		bit ok_iwr;
		bit ok_dsize;
		ok_isize = 1'b1;
		ok_iwr = 1'b1;
		ok_dsize = 1'b1;
		if (inst_req) begin
			compare_value("port_access", "inst_size", word_size, inst_size, ok_isize);
			compare_value("port_access", "inst_wr", 32'd0, inst_wr, ok_iwr);
		end
		if (data_req)
			compare_value("port_access", "data_size", word_size, data_size, ok_dsize);
		if (!(ok_isize && ok_iwr && ok_dsize))
			port_errors++;
	endtask

	// writeback outputs are stable at the falling edge
	always @(negedge clk) begin
		if (!reset && debug_wb_rf_wen != 4'b0000)
			check_write();
		if (!reset)
			check_ports();
	end

	initial begin : run
		int i;
		bit timed_out;
		timed_out = 1'b0;
		reset = 1'b1;
		$readmemh("test/cpu_testdata.txt", tdata);
		for (i = 0; i < 64; i++)
			u_imem.mem[i] = tdata[i];
		for (i = 0; i < 16; i++)
			u_dmem.mem[i] = tdata[data_base + i];
		while (trace_base + 3 * trace_len < 256
				&& tdata[trace_base + 3 * trace_len] !== 32'hffff_ffff)
			trace_len++;
		limit = trace_len * cycles_per_write + timeout_slack;
		repeat (10) @(posedge clk);
		#1 reset = 1'b0;
		while (trace_idx < trace_len && cycle_cnt < limit) begin
			@(posedge clk);
			cycle_cnt++;
		end
		if (trace_idx < trace_len) begin
			timed_out = 1'b1;
			$display("timeout after %0d cycles, only %0d of %0d writes seen",
				cycle_cnt, trace_idx, trace_len);
		end else begin
			// any further write here is a duplicate or a skipped instruction
			repeat (settle_cycles) @(posedge clk);
		end
		if (port_errors == 0) begin
			pass_cnt++;
			$display("port_access ok");
		end else begin
			fail_cnt++;
			$display("port_access failed");
		end
		$display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && !timed_out)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

//--- test/cpu_testdata.txt
// @00 program words from 0xbfc00000, @40 data words from 0x100
// @50 expected writeback trace, columns pc, register number, data; ffffffff ends it
@00
24010100 24020007 2403fffd 3c041234 00432821 00433023 00623824 00824025
0062482a 0043502a 252b0005 016b6021 01826823 25a00001 000d7021 ac280004
8c2f0004 01e28021 8c310000 8c320008 124d0002 24130011 24140022 26750001
24160003 16c20002 02d6b821 24180077 12c20002 24190029 241a0030 175a0005
275b0001 0bf00024 0362e025 241d0035 ac3c000c 8c3e000c 03d1f821 0bf00027
00000000
@40
cafe0001 11111111 00000005 22222222
@50
bfc00000 01 00000100  bfc00004 02 00000007
bfc00008 03 fffffffd  bfc0000c 04 12340000
bfc00010 05 00000004  bfc00014 06 0000000a
bfc00018 07 00000005  bfc0001c 08 12340007
bfc00020 09 00000001  bfc00024 0a 00000000
bfc00028 0b 00000006  bfc0002c 0c 0000000c
bfc00030 0d 00000005  bfc00038 0e 00000005
bfc00040 0f 12340007  bfc00044 10 1234000e
bfc00048 11 cafe0001  bfc0004c 12 00000005
bfc00054 13 00000011  bfc0005c 15 00000012
bfc00060 16 00000003  bfc00068 17 00000006
bfc00074 19 00000029  bfc00078 1a 00000030
bfc00080 1b 00000031  bfc00088 1c 00000037
bfc00094 1e 00000037  bfc00098 1f cafe0038
ffffffff

//--- files.f
src/isa_pkg.sv
src/pipe_pkg.sv
src/sram_if.sv
src/fetch_stage.sv
src/decode_stage.sv
src/exec_stage.sv
src/mem_stage.sv
src/hazard_ctrl.sv
src/mycpu_top.sv
test/tb_top.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f files.f -o tb_sim \
	> build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1; cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || grep -q "TB PASSED" sim.log || exit 1
